/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache
RTL_TOP   ?= dcache_top
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= hdl/dcache_pkg.sv hdl/dcache_way_ram.sv hdl/dcache_repl.sv \
             hdl/dcache_ctrl.sv hdl/dcache_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/dcache_ctrl.sv */
module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter logic [15:0] IO_SEGMENT = 16'hbfaf
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ren,
    input  logic [3:0] wen,
    input  word_t      vaddr,
    input  word_t      write_data,
    output word_t      rdata,
    output logic       rdata_valid,
    output logic       ready,
    input  logic       mem_rrdy,
    output logic       mem_ren,
    output word_t      mem_raddr,
    input  logic       mem_rvalid,
    input  line_t      mem_rdata,
    input  logic       mem_wrdy,
    output logic       mem_wen,
    output word_t      mem_waddr,
    output line_t      mem_wdata,
    input  logic       mem_wfinish,
    output logic       io_ren,
    output word_t      io_raddr,
    input  logic       io_rvalid,
    input  word_t      io_rdata,
    output logic [3:0] io_wen,
    output word_t      io_waddr,
    output word_t      io_wdata,
    input  logic       io_wfinish,
    output index_t     rd_index,
    output logic       we0,
    output logic       we1,
    output index_t     wr_index,
    output tag_t       wr_tag,
    output line_t      wr_line,
    input  logic       rd_valid0,
    input  logic       rd_valid1,
    input  tag_t       rd_tag0,
    input  tag_t       rd_tag1,
    input  line_t      rd_line0,
    input  line_t      rd_line1,
    output index_t     repl_index,
    output logic       touch,
    output way_e       touch_way,
    output logic       mark_dirty,
    output logic       clean,
    input  way_e       victim,
    input  logic       victim_dirty
);

    cache_state_e state;
    cache_state_e next_state;

    logic       s1_valid;
    logic       s1_ren;
    logic [3:0] s1_wen;
    logic       s1_unc;
    word_t      s1_addr;
    word_t      s1_data;

    logic       s2_valid;
    logic       s2_ren;
    logic [3:0] s2_wen;
    logic       s2_unc;
    word_t      s2_addr;
    word_t      s2_data;

    logic       byp0;
    logic       byp1;
    tag_t       byp_tag;
    line_t      byp_line;
    line_t      refill_line;
    logic       issued;

    logic       accept;
    logic       stall;
    logic       s2_store;
    tag_t       s2_tag;
    index_t     s2_index;
    offset_t    s2_offset;
    logic       v0;
    logic       v1;
    tag_t       t0;
    tag_t       t1;
    line_t      l0;
    line_t      l1;
    logic       hit0;
    logic       hit1;
    logic       hit;
    logic       hit_go;
    way_e       hit_way;
    line_t      hit_line;
    word_t      hit_word;
    line_t      merged_line;
    tag_t       victim_tag;
    line_t      victim_line;

    assign s2_tag    = addr_tag(s2_addr);
    assign s2_index  = addr_index(s2_addr);
    assign s2_offset = addr_offset(s2_addr);
    assign s2_store  = |s2_wen;

    // last cycle's write to this set is newer than the RAM output
    assign v0 = byp0 | rd_valid0;
    assign v1 = byp1 | rd_valid1;
    assign t0 = byp0 ? byp_tag : rd_tag0;
    assign t1 = byp1 ? byp_tag : rd_tag1;
    assign l0 = byp0 ? byp_line : rd_line0;
    assign l1 = byp1 ? byp_line : rd_line1;

    assign hit0     = v0 && (t0 == s2_tag);
    assign hit1     = v1 && (t1 == s2_tag);
    assign hit      = s2_valid && !s2_unc && (hit0 || hit1);
    assign hit_go   = (state == IDLE) && hit;
    assign hit_way  = hit1 ? WAY1 : WAY0;
    assign hit_line = hit1 ? l1 : l0;
    assign hit_word = hit_line[{s2_offset, 5'b0} +: WORD_W];

    always_comb
    begin
        merged_line = hit_line;
        for (int b = 0; b < 4; b++)
        begin
            if (s2_wen[b])
                merged_line[{s2_offset, 5'b0} + 8*b +: 8] = s2_data[8*b +: 8];
        end
    end

    assign victim_tag  = (victim == WAY1) ? t1 : t0;
    assign victim_line = (victim == WAY1) ? l1 : l0;

    assign stall  = (state != IDLE) || (s2_valid && (s2_unc || !hit));
    assign ready  = !stall;
    assign accept = ready && (ren || (|wen));

    assign rd_index = stall ? s2_index : addr_index(s1_addr);   // hold set during a miss
    assign wr_index = s2_index;
    assign wr_tag   = s2_tag;
    assign wr_line  = (state == REFILL) ? refill_line : merged_line;
    assign we0      = (hit_go && s2_store && (hit_way == WAY0)) ||
                      ((state == REFILL) && (victim == WAY0));
    assign we1      = (hit_go && s2_store && (hit_way == WAY1)) ||
                      ((state == REFILL) && (victim == WAY1));

    assign repl_index = s2_index;
    assign touch      = hit_go || (state == REFILL);
    assign touch_way  = (state == REFILL) ? victim : hit_way;
    assign mark_dirty = touch && s2_store;
    assign clean      = mem_wen;

    assign mem_ren   = (state == ASK_MEM) && !issued && mem_rrdy;
    assign mem_raddr = line_base(s2_tag, s2_index);
    assign mem_wen   = (state == WRITE_BACK) && !issued && mem_wrdy;
    assign mem_waddr = line_base(victim_tag, s2_index);    // evicted line's own tag
    assign mem_wdata = victim_line;

    assign io_ren   = (state == UNCACHED) && s2_ren && !issued && mem_rrdy;
    assign io_raddr = s2_addr;
    assign io_wen   = ((state == UNCACHED) && s2_store && !issued && mem_wrdy) ? s2_wen : 4'b0;
    assign io_waddr = s2_addr;
    assign io_wdata = s2_data;

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (s2_valid && s2_unc)
                    next_state = UNCACHED;
                else if (s2_valid && !hit)
                    next_state = victim_dirty ? WRITE_BACK : ASK_MEM;
            end
            WRITE_BACK:
            begin
                if (mem_wfinish)
                    next_state = ASK_MEM;
            end
            ASK_MEM:
            begin
                if (mem_rvalid)
                    next_state = REFILL;
            end
            REFILL:   next_state = RETURN;
            RETURN:   next_state = IDLE;    // re-read set, lookup then hits
            UNCACHED:
            begin
                if (io_rvalid || io_wfinish)
                    next_state = IDLE;
            end
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state       <= IDLE;
            issued      <= 1'b0;
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            byp0        <= 1'b0;
            byp1        <= 1'b0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (next_state != state)
                issued <= 1'b0;
            else if (mem_ren || mem_wen || io_ren || (|io_wen))
                issued <= 1'b1;
            byp0        <= we0 && (wr_index == rd_index);
            byp1        <= we1 && (wr_index == rd_index);
            rdata_valid <= (hit_go && s2_ren) || ((state == UNCACHED) && io_rvalid);
            if (!stall)
            begin
                s1_valid <= accept;
                s2_valid <= s1_valid;
            end
            else if ((state == UNCACHED) && (io_rvalid || io_wfinish))
                s2_valid <= 1'b0;   // io request retired
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            s1_ren  <= ren;
            s1_wen  <= wen;
            s1_unc  <= vaddr[31:16] == IO_SEGMENT;
            s1_addr <= vaddr;
            s1_data <= write_data;
        end
        if (!stall)
        begin
            s2_ren  <= s1_ren;
            s2_wen  <= s1_wen;
            s2_unc  <= s1_unc;
            s2_addr <= s1_addr;
            s2_data <= s1_data;
        end
        if (we0 || we1)
        begin
            byp_tag  <= wr_tag;
            byp_line <= wr_line;
        end
        if ((state == ASK_MEM) && mem_rvalid)
            refill_line <= mem_rdata;
        if (hit_go && s2_ren)
            rdata <= hit_word;
        else if ((state == UNCACHED) && io_rvalid)
            rdata <= io_rdata;
    end

    a_one_mem_op: assert property (@(posedge clk) disable iff (!rst)
        !(mem_ren && mem_wen));

    a_cpu_proto: assert property (@(posedge clk) disable iff (!rst)
        !ready |-> !(ren || (|wen)));

    a_io_state: assert property (@(posedge clk) disable iff (!rst)
        (io_ren || (|io_wen)) |-> (state == UNCACHED));

endmodule

/* hdl/dcache_pkg.sv */
package dcache_pkg;

    localparam int WORD_W   = 32;
    localparam int BYTE_W   = 2;            // byte position inside a word
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = WORD_W - INDEX_W - OFFSET_W - BYTE_W;
    localparam int LINE_W   = WORD_W << OFFSET_W;
    localparam int NUM_SETS = 1 << INDEX_W;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    typedef enum logic
    {
        WAY0,
        WAY1
    } way_e;

    typedef enum logic [2:0]
    {
        IDLE,
        WRITE_BACK,
        ASK_MEM,
        REFILL,
        RETURN,
        UNCACHED
    } cache_state_e;

    function automatic tag_t addr_tag(word_t addr);
        return addr[BYTE_W+OFFSET_W+INDEX_W +: TAG_W];
    endfunction

    function automatic index_t addr_index(word_t addr);
        return addr[BYTE_W+OFFSET_W +: INDEX_W];
    endfunction

    function automatic offset_t addr_offset(word_t addr);
        return addr[BYTE_W +: OFFSET_W];
    endfunction

    // first byte address of the line holding tag and index
    function automatic word_t line_base(tag_t tag, index_t index);
        return {tag, index, {(OFFSET_W+BYTE_W){1'b0}}};
    endfunction

endpackage

/* hdl/dcache_repl.sv */
module dcache_repl
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  index_t index,
    input  logic   touch,
    input  way_e   touch_way,
    input  logic   mark_dirty,
    input  logic   clean,
    output way_e   victim,
    output logic   victim_dirty
);

    way_e       lru   [NUM_SETS];   // way to evict next
    logic [1:0] dirty [NUM_SETS];   // one bit per way

    assign victim       = lru[index];
    assign victim_dirty = dirty[index][victim];

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                lru[s]   <= WAY0;
                dirty[s] <= 2'b00;
            end
        end
        else
        begin
            if (touch)
                lru[index] <= (touch_way == WAY0) ? WAY1 : WAY0;
            if (mark_dirty)
                dirty[index][touch_way] <= 1'b1;
            if (clean)
                dirty[index][victim] <= 1'b0;   // line is on its way out
        end
    end

    // only a dirty victim is written back, and only once
    a_clean_dirty: assert property (@(posedge clk) disable iff (!rst)
        clean |-> victim_dirty);

endmodule

/* hdl/dcache_top.sv */
module dcache_top
    import dcache_pkg::*;
#(
    parameter logic [15:0] IO_SEGMENT = 16'hbfaf
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ren,
    input  logic [3:0] wen,
    input  word_t      vaddr,
    input  word_t      write_data,
    output word_t      rdata,
    output logic       rdata_valid,
    output logic       ready,
    input  logic       mem_rrdy,
    output logic       mem_ren,
    output word_t      mem_raddr,
    input  logic       mem_rvalid,
    input  line_t      mem_rdata,
    input  logic       mem_wrdy,
    output logic       mem_wen,
    output word_t      mem_waddr,
    output line_t      mem_wdata,
    input  logic       mem_wfinish,
    output logic       io_ren,
    output word_t      io_raddr,
    input  logic       io_rvalid,
    input  word_t      io_rdata,
    output logic [3:0] io_wen,
    output word_t      io_waddr,
    output word_t      io_wdata,
    input  logic       io_wfinish
);

    index_t rd_index;
    index_t wr_index;
    index_t repl_index;
    logic   we0;
    logic   we1;
    tag_t   wr_tag;
    line_t  wr_line;
    logic   rd_valid0;
    logic   rd_valid1;
    tag_t   rd_tag0;
    tag_t   rd_tag1;
    line_t  rd_line0;
    line_t  rd_line1;
    logic   touch;
    way_e   touch_way;
    logic   mark_dirty;
    logic   clean;
    way_e   victim;
    logic   victim_dirty;

    dcache_ctrl #(
        .IO_SEGMENT (IO_SEGMENT)
    ) u_ctrl (
        .*
    );

    dcache_way_ram way0 (
        .clk      (clk),
        .rst      (rst),
        .we       (we0),
        .wr_index (wr_index),
        .rd_index (rd_index),
        .wr_tag   (wr_tag),
        .wr_line  (wr_line),
        .rd_valid (rd_valid0),
        .rd_tag   (rd_tag0),
        .rd_line  (rd_line0)
    );

    dcache_way_ram way1 (
        .clk      (clk),
        .rst      (rst),
        .we       (we1),
        .wr_index (wr_index),
        .rd_index (rd_index),
        .wr_tag   (wr_tag),
        .wr_line  (wr_line),
        .rd_valid (rd_valid1),
        .rd_tag   (rd_tag1),
        .rd_line  (rd_line1)
    );

    dcache_repl u_repl (
        .index (repl_index),
        .*
    );

endmodule

/* hdl/dcache_way_ram.sv */
module dcache_way_ram
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   we,
    input  index_t wr_index,
    input  index_t rd_index,
    input  tag_t   wr_tag,
    input  line_t  wr_line,
    output logic   rd_valid,
    output tag_t   rd_tag,
    output line_t  rd_line
);

    logic [NUM_SETS-1:0] valid;
    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            valid    <= '0;
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= valid[rd_index];    // old entry on same-index write
            if (we)
                valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        rd_tag  <= tag_mem[rd_index];
        rd_line <= line_mem[rd_index];
        if (we)
        begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
    end

    a_we_index: assert property (@(posedge clk) disable iff (!rst)
        we |-> !$isunknown(wr_index));

endmodule

/* tb.f */
hdl/dcache_pkg.sv
hdl/dcache_way_ram.sv
hdl/dcache_repl.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tb/mem_model.sv
tb/tb_dcache.sv

/* tb/mem_model.sv */
module mem_model
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    output logic       mem_rrdy,
    input  logic       mem_ren,
    input  word_t      mem_raddr,
    output logic       mem_rvalid,
    output line_t      mem_rdata,
    output logic       mem_wrdy,
    input  logic       mem_wen,
    input  word_t      mem_waddr,
    input  line_t      mem_wdata,
    output logic       mem_wfinish,
    input  logic       io_ren,
    input  word_t      io_raddr,
    output logic       io_rvalid,
    output word_t      io_rdata,
    input  logic [3:0] io_wen,
    input  word_t      io_waddr,
    input  word_t      io_wdata,
    output logic       io_wfinish
);
    timeunit 1ns;
    timeprecision 100ps;

    int    seed = 32'he4f1;
    word_t mem [word_t];        // written words only, rest comes from the fill
    word_t io_regs [word_t];
    logic  rd_busy;
    logic  wr_busy;
    logic  io_busy;
    logic  io_read;
    int    rd_wait;
    int    wr_wait;
    int    io_wait;
    word_t rd_addr;
    word_t io_addr;

    function automatic word_t mem_fill(word_t a);
        return {a[15:0], a[31:16]} ^ a ^ 32'h6b2d_9e41;
    endfunction

    function automatic word_t io_fill(word_t a);
        return ~a ^ 32'h0f0f_3c3c;
    endfunction

    function automatic int latency();
        return 1 + (($random(seed) & 32'h7fff_ffff) % 6);   // 1 to 6 cycles
    endfunction

    function automatic line_t read_line(word_t base);
        line_t l;
        word_t a;
        for (int i = 0; i < 4; i++)
        begin
            a = base + 4 * i;
            l[32*i +: 32] = mem.exists(a) ? mem[a] : mem_fill(a);
        end
        return l;
    endfunction

    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            mem_rrdy    <= 1'b0;
            mem_wrdy    <= 1'b0;
            mem_rvalid  <= 1'b0;
            mem_wfinish <= 1'b0;
            io_rvalid   <= 1'b0;
            io_wfinish  <= 1'b0;
            mem_rdata   <= '0;
            io_rdata    <= '0;
            rd_busy     <= 1'b0;
            wr_busy     <= 1'b0;
            io_busy     <= 1'b0;
        end
        else
        begin
            mem_rvalid  <= 1'b0;
            mem_wfinish <= 1'b0;
            io_rvalid   <= 1'b0;
            io_wfinish  <= 1'b0;
            mem_rrdy    <= !rd_busy && !mem_ren && !io_busy && !io_ren &&
                           (($random(seed) & 3) != 0);
            mem_wrdy    <= !wr_busy && !mem_wen && !io_busy && (io_wen == 4'b0) &&
                           (($random(seed) & 3) != 0);
            if (mem_ren)
            begin
                rd_busy <= 1'b1;
                rd_addr <= mem_raddr;
                rd_wait <= latency();
            end
            else if (rd_busy)
            begin
                if (rd_wait <= 1)
                begin
                    rd_busy    <= 1'b0;
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= read_line(rd_addr);
                end
                else
                    rd_wait <= rd_wait - 1;
            end
            if (mem_wen)
            begin
                for (int i = 0; i < 4; i++)
                    mem[mem_waddr + 4 * i] = mem_wdata[32*i +: 32];
                wr_busy <= 1'b1;
                wr_wait <= latency();
            end
            else if (wr_busy)
            begin
                if (wr_wait <= 1)
                begin
                    wr_busy     <= 1'b0;
                    mem_wfinish <= 1'b1;
                end
                else
                    wr_wait <= wr_wait - 1;
            end
            if (io_ren || (io_wen != 4'b0))
            begin
                if (!io_regs.exists(io_waddr))
                    io_regs[io_waddr] = io_fill(io_waddr);
                for (int b = 0; b < 4; b++)
                    if (io_wen[b])
                        io_regs[io_waddr][8*b +: 8] = io_wdata[8*b +: 8];
                io_busy <= 1'b1;
                io_read <= io_ren;
                io_addr <= io_raddr;
                io_wait <= latency();
            end
            else if (io_busy)
            begin
                if (io_wait <= 1)
                begin
                    io_busy <= 1'b0;
                    if (io_read)
                    begin
                        io_rvalid <= 1'b1;
                        io_rdata  <= io_regs.exists(io_addr) ? io_regs[io_addr]
                                                              : io_fill(io_addr);
                    end
                    else
                        io_wfinish <= 1'b1;
                end
                else
                    io_wait <= io_wait - 1;
            end
        end
    end

endmodule

/* tb/tb_dcache.sv */
module tb_dcache
    import dcache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD   = 8;
    localparam int MAX_LAT  = 6;
    localparam int HIT_WAIT = 3;    // negedges from accept to rdata_valid

    typedef enum {OP_LOAD, OP_STORE, OP_ULOAD, OP_USTORE, OP_IDLE} op_kind_e;

    typedef struct {
        op_kind_e   kind;
        word_t      addr;
        word_t      data;
        logic [3:0] be;
        int         exp_reads;      // -1 means not checked
        int         exp_wb;
        word_t      wb_addr;
        bit         exp_hit;
    } op_t;

    logic clk = 1'b0;
    logic rst;
    logic ren;
    logic [3:0] wen;
    word_t vaddr;
    word_t write_data;
    word_t rdata;
    logic rdata_valid;
    logic ready;
    logic mem_rrdy, mem_ren, mem_rvalid, mem_wrdy, mem_wen, mem_wfinish;
    word_t mem_raddr, mem_waddr;
    line_t mem_rdata, mem_wdata;
    logic io_ren, io_rvalid, io_wfinish;
    logic [3:0] io_wen;
    word_t io_raddr, io_rdata, io_waddr, io_wdata;

    int seed = 32'he4f1;
    op_t ops[$];
    word_t shadow [word_t];
    word_t io_shadow [word_t];
    int cycles = 0;
    int limit = 0;
    int errors = 0;
    int test_err;
    int n_pass = 0;
    int n_fail = 0;
    word_t rd_addrs[$];
    word_t wb_addrs[$];
    word_t io_rd_addrs[$];
    word_t io_wr_addrs[$];
    word_t io_wr_data[$];
    logic [3:0] io_wr_be[$];
    int rd_cycle;
    int wf_cycle;

    always #(PERIOD / 2) clk = ~clk;

    dcache_top #(.IO_SEGMENT(16'hbfaf)) DUT (.*);

    mem_model dev (.*);

    function automatic word_t mem_init(word_t a);
        return {a[15:0], a[31:16]} ^ a ^ 32'h6b2d_9e41;     // same contents as the model
    endfunction

    function automatic word_t shadow_word(word_t a);
        return shadow.exists(a) ? shadow[a] : mem_init(a);
    endfunction

    function automatic word_t io_word(word_t a);
        return io_shadow.exists(a) ? io_shadow[a] : ~a ^ 32'h0f0f_3c3c;
    endfunction

    function automatic line_t shadow_line(word_t base);
        line_t l;
        for (int i = 0; i < 4; i++)
            l[32*i +: 32] = shadow_word(base + 4 * i);
        return l;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t data, logic [3:0] be);
        word_t w;
        w = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                w[8*b +: 8] = data[8*b +: 8];
        return w;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp)
        begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_addr(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
        begin
            $display("%0t: saw %0d %s, expected %0d", $time, got, what, exp);
            test_err++;
        end
    endtask

    task automatic add_op(input op_kind_e kind, input word_t addr, input word_t data,
                          input logic [3:0] be, input int exp_reads, input int exp_wb,
                          input word_t wb_addr, input bit exp_hit);
        op_t op;
        op.kind      = kind;
        op.addr      = addr;
        op.data      = data;
        op.be        = be;
        op.exp_reads = exp_reads;
        op.exp_wb    = exp_wb;
        op.wb_addr   = wb_addr;
        op.exp_hit   = exp_hit;
        ops.push_back(op);
    endtask

    // bus traffic, sampled where the combinational strobes are settled
    always @(negedge clk)
    begin
        if (rst)
        begin
            if (mem_ren)
            begin
                rd_addrs.push_back(mem_raddr);
                rd_cycle = cycles;
            end
            if (mem_wen)
            begin
                wb_addrs.push_back(mem_waddr);
                check_line("mem_wdata", mem_wdata, shadow_line(mem_waddr));
            end
            if (mem_wfinish)
                wf_cycle = cycles;
            if (io_ren)
                io_rd_addrs.push_back(io_raddr);
            if (io_wen != 4'b0)
            begin
                io_wr_addrs.push_back(io_waddr);
                io_wr_data.push_back(io_wdata);
                io_wr_be.push_back(io_wen);
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (limit > 0 && cycles > limit)
        begin
            $display("timeout: no finish after %0d cycles, controller in state %s",
                     cycles, DUT.u_ctrl.state.name());
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic run_op(input int num, input op_t op);
        bit is_load;
        int waited;
        word_t base;
        is_load = (op.kind == OP_LOAD) || (op.kind == OP_ULOAD);
        base = {op.addr[31:4], 4'b0};
        test_err = 0;
        @(posedge clk);
        rd_addrs.delete();
        wb_addrs.delete();
        io_rd_addrs.delete();
        io_wr_addrs.delete();
        io_wr_data.delete();
        io_wr_be.delete();
        rd_cycle = -1;
        wf_cycle = -1;
        if (op.kind == OP_IDLE)
            repeat (3) @(posedge clk);
        else
        begin
            ren        <= is_load;
            wen        <= is_load ? 4'b0 : op.be;
            vaddr      <= op.addr;
            write_data <= op.data;
            @(posedge clk);     // accepted here
            ren <= 1'b0;
            wen <= 4'b0;
            waited = 0;
            if (is_load)
            begin
                do
                begin
                    @(negedge clk);
                    waited++;
                end
                while (!rdata_valid);
                if (op.kind == OP_LOAD)
                    check_word("rdata", rdata, shadow_word(op.addr));
                else
                    check_word("rdata", rdata, io_word(op.addr));
                if (op.exp_hit && waited != HIT_WAIT)
                begin
                    $display("%0t: load hit answered after %0d cycles, expected %0d",
                             $time, waited, HIT_WAIT);
                    test_err++;
                end
            end
            else
            begin
                repeat (2) @(negedge clk);
                while (!ready)
                    @(negedge clk);
                if (op.kind == OP_STORE)
                    shadow[op.addr] = merge_bytes(shadow_word(op.addr), op.data, op.be);
                else
                    io_shadow[op.addr] = merge_bytes(io_word(op.addr), op.data, op.be);
            end
        end
        if (op.exp_reads >= 0)
            check_count("line reads", rd_addrs.size(), op.exp_reads);
        if (op.exp_reads == 1 && rd_addrs.size() == 1)
            check_addr("mem_raddr", rd_addrs[0], base);
        if (op.exp_wb >= 0)
            check_count("line write-backs", wb_addrs.size(), op.exp_wb);
        if (op.exp_wb == 1 && wb_addrs.size() == 1)
        begin
            check_addr("mem_waddr", wb_addrs[0], op.wb_addr);
            if (wf_cycle < 0 || wf_cycle >= rd_cycle)
            begin
                $display("%0t: write-back did not finish before the line read", $time);
                test_err++;
            end
        end
        if (op.kind == OP_ULOAD)
        begin
            check_count("io reads", io_rd_addrs.size(), 1);
            if (io_rd_addrs.size() == 1)
                check_addr("io_raddr", io_rd_addrs[0], op.addr);
        end
        if (op.kind == OP_USTORE)
        begin
            check_count("io writes", io_wr_addrs.size(), 1);
            if (io_wr_addrs.size() == 1)
            begin
                check_addr("io_waddr", io_wr_addrs[0], op.addr);
                check_word("io_wdata", io_wr_data[0], op.data);
                check_word("io_wen", {28'b0, io_wr_be[0]}, {28'b0, op.be});
            end
        end
        errors += test_err;
        if (test_err == 0)
            n_pass++;
        else
            n_fail++;
        $display("test %0d %s %h: %s", num, op.kind.name(), op.addr,
                 (test_err == 0) ? "ok" : "wrong");
    endtask

    initial
    begin
        word_t a;
        rst        = 1'b0;
        ren        = 1'b0;
        wen        = 4'b0;
        vaddr      = '0;
        write_data = '0;

        add_op(OP_IDLE,  32'h0, 32'h0, 4'b0, 0, 0, 32'h0, 0);
        add_op(OP_LOAD,  32'h0000_1230, 32'h0, 4'b0, 1, 0, 32'h0, 0);  // clean miss
        add_op(OP_LOAD,  32'h0000_1238, 32'h0, 4'b0, 0, 0, 32'h0, 1);
        add_op(OP_STORE, 32'h0000_1234, 32'ha1b2_c3d4, 4'b0110, 0, 0, 32'h0, 0);
        add_op(OP_LOAD,  32'h0000_1234, 32'h0, 4'b0, 0, 0, 32'h0, 1);
        add_op(OP_STORE, 32'h0001_0050, 32'h1111_1111, 4'b1111, 1, 0, 32'h0, 0);
        add_op(OP_STORE, 32'h0002_0054, 32'h2222_2222, 4'b1111, 1, 0, 32'h0, 0);
        add_op(OP_STORE, 32'h0003_0058, 32'h3333_3333, 4'b1111, 1, 1, 32'h0001_0050, 0);
        add_op(OP_ULOAD, 32'hbfaf_0010, 32'h0, 4'b0, 0, 0, 32'h0, 0);
        add_op(OP_USTORE, 32'hbfaf_0020, 32'h1122_3344, 4'b1001, 0, 0, 32'h0, 0);
        add_op(OP_ULOAD, 32'hbfaf_0020, 32'h0, 4'b0, 0, 0, 32'h0, 0);
        for (int i = 0; i < 48; i++)
        begin
            a = ((1 + (($random(seed) & 32'hff) % 3)) << 10) |
                (($random(seed) & 7) << 4) | (($random(seed) & 3) << 2);
            if ($random(seed) & 1)
                add_op(OP_LOAD, a, 32'h0, 4'b0, -1, -1, 32'h0, 0);
            else
                add_op(OP_STORE, a, $random(seed), 4'(1 + (($random(seed) & 32'hff) % 15)),
                       -1, -1, 32'h0, 0);
        end
        limit = ops.size() * (2 * MAX_LAT + 8) + 10;

        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        test_err = 0;
        check_flag("ready", ready, 1'b1);
        check_flag("rdata_valid", rdata_valid, 1'b0);
        check_flag("mem_ren", mem_ren, 1'b0);
        check_flag("mem_wen", mem_wen, 1'b0);
        check_flag("io_ren", io_ren, 1'b0);
        check_flag("io_wen", |io_wen, 1'b0);
        errors += test_err;
        if (test_err == 0)
            n_pass++;
        else
            n_fail++;
        $display("test reset state: %s", (test_err == 0) ? "ok" : "wrong");

        foreach (ops[i])
            run_op(i, ops[i]);

        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
